//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_pipe_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
source/rv_isa_pkg.sv
source/rv_bus_pkg.sv
source/rv_alu.sv
source/rv_reg_file.sv
source/rv_decoder.sv
source/rv_pipe_core.sv
source/rv_host_regs.sv
source/rv_memories.sv
source/rv_pipe_top.sv
verification/rv_pipe_assertions.sv
verification/rv_pipe_tb.sv

//--- source/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_bus_pkg::word_t    a,
    input  rv_bus_pkg::word_t    b,
    input  rv_isa_pkg::alu_op_e  op,
    output rv_bus_pkg::word_t    result,
    output logic                 equal
);

    always_comb begin
        case (op)
            rv_isa_pkg::ADD:    result = a + b;
            rv_isa_pkg::SUB:    result = a - b;
            rv_isa_pkg::AND:    result = a & b;
            rv_isa_pkg::OR:     result = a | b;
            rv_isa_pkg::XOR:    result = a ^ b;
            // shift amount from the low five bits only
            rv_isa_pkg::SLL:    result = a << b[4:0];
            rv_isa_pkg::SRL:    result = a >> b[4:0];
            rv_isa_pkg::SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::PASS_B: result = b;
            default:            result = '0;
        endcase
    end

    // branch compare on rs1 and rs2
    assign equal = (a == b);

endmodule : rv_alu

//--- source/rv_bus_pkg.sv
package rv_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [11:0] wb_adr_t;

    // host port map, 1 KB per region
    localparam wb_adr_t IMEM_BASE  = 12'h000;
    localparam wb_adr_t DMEM_BASE  = 12'h400;

    // run in bit 0
    localparam wb_adr_t REG_CTRL   = 12'h800;
    localparam wb_adr_t REG_STOP   = 12'h804;
    // done in bit 0, run in bit 1
    localparam wb_adr_t REG_STATUS = 12'h808;

endpackage : rv_bus_pkg

//--- source/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_bus_pkg::word_t    instr,
    output rv_isa_pkg::alu_op_e  alu_op,
    output rv_bus_pkg::word_t    imm,
    output logic                 use_imm,
    output logic                 reg_we,
    output logic                 mem_we,
    output logic                 mem_to_reg,
    output logic                 branch,
    output logic                 branch_ne
);

    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_isa_pkg::imm_sel_e  imm_sel;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op     = rv_isa_pkg::ADD;
        imm_sel    = rv_isa_pkg::I;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_we     = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        // anything not matched below leaves all enables low
        case (rv_isa_pkg::opcode_e'(instr[6:0]))
            rv_isa_pkg::OP: begin
                reg_we = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        if (funct7 == rv_isa_pkg::F7_SUB) begin
                            alu_op = rv_isa_pkg::SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLL: alu_op = rv_isa_pkg::SLL;
                    rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::SLT;
                    rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::XOR;
                    rv_isa_pkg::F3_SRL: alu_op = rv_isa_pkg::SRL;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::OR;
                    rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::AND;
                    default:            reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_IMM: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: alu_op = rv_isa_pkg::ADD;
                    rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::AND;
                    rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::OR;
                    default:                reg_we = 1'b0;
                endcase
            end
            rv_isa_pkg::LUI: begin
                imm_sel = rv_isa_pkg::U;
                alu_op  = rv_isa_pkg::PASS_B;
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            rv_isa_pkg::LOAD: begin
                use_imm    = 1'b1;
                reg_we     = (funct3 == rv_isa_pkg::F3_WORD);
                mem_to_reg = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                imm_sel = rv_isa_pkg::S;
                use_imm = 1'b1;
                mem_we  = (funct3 == rv_isa_pkg::F3_WORD);
            end
            rv_isa_pkg::BRANCH: begin
                imm_sel   = rv_isa_pkg::B;
                alu_op    = rv_isa_pkg::SUB;
                branch    = (funct3 == rv_isa_pkg::F3_BEQ) || (funct3 == rv_isa_pkg::F3_BNE);
                branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_sel)
            rv_isa_pkg::I: imm = {{20{instr[31]}}, instr[31:20]};
            rv_isa_pkg::S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_isa_pkg::B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:       imm = {instr[31:12], 12'b0};
        endcase
    end

endmodule : rv_decoder

//--- source/rv_host_regs.sv
`timescale 1ns/1ps

module rv_host_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  rv_bus_pkg::wb_adr_t  adr,
    input  rv_bus_pkg::word_t    dat_w,
    input  rv_bus_pkg::addr_t    instr_addr,
    input  rv_bus_pkg::word_t    dmem_host_rdata,
    output rv_bus_pkg::word_t    dat_r,
    output logic                 ack,
    output logic                 run,
    output logic                 imem_we,
    output logic                 dmem_host_stb,
    output logic                 dmem_host_we,
    output logic [9:0]           host_index,
    output rv_bus_pkg::word_t    host_wdata
);

    logic               access;
    logic               sel_imem;
    logic               sel_dmem;
    logic               done;
    rv_bus_pkg::addr_t  stop_addr;
    rv_bus_pkg::word_t  reg_rdata;

    // request not yet acknowledged
    assign access   = cyc && stb && !ack;
    assign sel_imem = (adr[11:10] == rv_bus_pkg::IMEM_BASE[11:10]);
    assign sel_dmem = (adr[11:10] == rv_bus_pkg::DMEM_BASE[11:10]);

    assign imem_we       = access && we && sel_imem;
    assign dmem_host_stb = access && sel_dmem;
    assign dmem_host_we  = we;
    // word index inside the 1 KB region
    assign host_index    = {2'b00, adr[9:2]};
    assign host_wdata    = dat_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            run       <= 1'b0;
            done      <= 1'b0;
            stop_addr <= '0;
        end else begin
            ack <= access;
            if (access && we && adr == rv_bus_pkg::REG_STOP) begin
                stop_addr <= dat_w;
            end
            // host write wins over a stop match in the same cycle
            if (access && we && adr == rv_bus_pkg::REG_CTRL) begin
                run  <= dat_w[0];
                done <= done && !dat_w[0];
            end else if (run && instr_addr == stop_addr) begin
                run  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        case (adr)
            rv_bus_pkg::REG_CTRL:   reg_rdata = {31'b0, run};
            rv_bus_pkg::REG_STOP:   reg_rdata = stop_addr;
            rv_bus_pkg::REG_STATUS: reg_rdata = {30'b0, run, done};
            default:                reg_rdata = '0;
        endcase
    end

    // adr is held through ack, so the select is still valid here
    assign dat_r = sel_dmem ? dmem_host_rdata : reg_rdata;

endmodule : rv_host_regs

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SLT    = 4'd7,
        PASS_B = 4'd8
    } alu_op_e;

    // immediate layouts
    typedef enum logic [1:0] {
        I = 2'd0,
        S = 2'd1,
        B = 2'd2,
        U = 2'd3
    } imm_sel_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    // lw and sw, the only access size
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage : rv_isa_pkg

//--- source/rv_memories.sv
`timescale 1ns/1ps

module rv_memories #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               imem_we,
    input  logic               dmem_host_stb,
    input  logic               dmem_host_we,
    input  logic [9:0]         host_index,
    input  rv_bus_pkg::word_t  host_wdata,
    input  rv_bus_pkg::addr_t  instr_addr,
    input  rv_bus_pkg::addr_t  addr_dm,
    input  logic               we_dm,
    input  rv_bus_pkg::word_t  wd_dm,
    output rv_bus_pkg::word_t  instr,
    output rv_bus_pkg::word_t  rd_dm,
    output rv_bus_pkg::word_t  dmem_host_rdata
);

    localparam int IW = $clog2(IMEM_WORDS);
    localparam int DW = $clog2(DMEM_WORDS);

    rv_bus_pkg::word_t imem [IMEM_WORDS];
    rv_bus_pkg::word_t dmem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[host_index[IW-1:0]] <= host_wdata;
        end
    end

    // combinational fetch
    assign instr = imem[instr_addr[IW+1:2]];

    // core port and host port share one array
    always_ff @(posedge clk) begin
        if (we_dm) begin
            dmem[addr_dm[DW+1:2]] <= wd_dm;
        end
        if (dmem_host_stb && dmem_host_we) begin
            dmem[host_index[DW-1:0]] <= host_wdata;
        end
        rd_dm <= dmem[addr_dm[DW+1:2]];
        // lands in the ack cycle
        if (dmem_host_stb) begin
            dmem_host_rdata <= dmem[host_index[DW-1:0]];
        end
    end

endmodule : rv_memories

//--- source/rv_pipe_core.sv
`timescale 1ns/1ps

module rv_pipe_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  rv_bus_pkg::word_t  instr,
    input  rv_bus_pkg::word_t  rd_dm,
    output rv_bus_pkg::addr_t  instr_addr,
    output rv_bus_pkg::addr_t  addr_dm,
    output logic               we_dm,
    output rv_bus_pkg::word_t  wd_dm
);

    rv_bus_pkg::addr_t      pc;
    // IF/ID
    rv_bus_pkg::word_t      if_id_instr;
    rv_bus_pkg::addr_t      if_id_pc;
    // decode
    rv_isa_pkg::alu_op_e    dec_alu_op;
    rv_bus_pkg::word_t      dec_imm;
    logic                   dec_use_imm;
    logic                   dec_reg_we;
    logic                   dec_mem_we;
    logic                   dec_mem_to_reg;
    logic                   dec_branch;
    logic                   dec_branch_ne;
    rv_bus_pkg::word_t      rf_rd1;
    rv_bus_pkg::word_t      rf_rd2;
    // ID/EX
    rv_bus_pkg::addr_t      id_ex_pc;
    rv_bus_pkg::word_t      id_ex_rd1;
    rv_bus_pkg::word_t      id_ex_rd2;
    rv_bus_pkg::word_t      id_ex_imm;
    rv_isa_pkg::reg_addr_t  id_ex_rd;
    rv_isa_pkg::alu_op_e    id_ex_alu_op;
    logic                   id_ex_use_imm;
    logic                   id_ex_reg_we;
    logic                   id_ex_mem_we;
    logic                   id_ex_mem_to_reg;
    logic                   id_ex_branch;
    logic                   id_ex_branch_ne;
    // execute
    rv_bus_pkg::word_t      alu_b;
    rv_bus_pkg::word_t      alu_result;
    logic                   alu_equal;
    logic                   branch_taken;
    rv_bus_pkg::addr_t      branch_target;
    // EX/MEM
    rv_bus_pkg::word_t      ex_mem_result;
    rv_bus_pkg::word_t      ex_mem_rd2;
    rv_isa_pkg::reg_addr_t  ex_mem_rd;
    logic                   ex_mem_reg_we;
    logic                   ex_mem_mem_we;
    logic                   ex_mem_mem_to_reg;
    // MEM/WB
    rv_bus_pkg::word_t      mem_wb_result;
    rv_isa_pkg::reg_addr_t  mem_wb_rd;
    logic                   mem_wb_reg_we;
    logic                   mem_wb_mem_to_reg;
    rv_bus_pkg::word_t      wb_data;

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (run) begin
            pc <= branch_taken ? branch_target : pc + 32'd4;
        end
    end

    // stage valid bits and enables, all held while run is low
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_instr       <= rv_isa_pkg::NOP_INSTR;
            id_ex_reg_we      <= 1'b0;
            id_ex_mem_we      <= 1'b0;
            id_ex_mem_to_reg  <= 1'b0;
            id_ex_branch      <= 1'b0;
            ex_mem_reg_we     <= 1'b0;
            ex_mem_mem_we     <= 1'b0;
            ex_mem_mem_to_reg <= 1'b0;
            mem_wb_reg_we     <= 1'b0;
            mem_wb_mem_to_reg <= 1'b0;
        end else if (run) begin
            // taken branch squashes fetch and decode
            if_id_instr       <= branch_taken ? rv_isa_pkg::NOP_INSTR : instr;
            id_ex_reg_we      <= dec_reg_we && !branch_taken;
            id_ex_mem_we      <= dec_mem_we && !branch_taken;
            id_ex_mem_to_reg  <= dec_mem_to_reg && !branch_taken;
            id_ex_branch      <= dec_branch && !branch_taken;
            ex_mem_reg_we     <= id_ex_reg_we;
            ex_mem_mem_we     <= id_ex_mem_we;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
            mem_wb_reg_we     <= ex_mem_reg_we;
            mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            if_id_pc        <= pc;
            id_ex_pc        <= if_id_pc;
            id_ex_rd1       <= rf_rd1;
            id_ex_rd2       <= rf_rd2;
            id_ex_imm       <= dec_imm;
            id_ex_rd        <= if_id_instr[11:7];
            id_ex_alu_op    <= dec_alu_op;
            id_ex_use_imm   <= dec_use_imm;
            id_ex_branch_ne <= dec_branch_ne;
            ex_mem_result   <= alu_result;
            ex_mem_rd2      <= id_ex_rd2;
            ex_mem_rd       <= id_ex_rd;
            mem_wb_result   <= ex_mem_result;
            mem_wb_rd       <= ex_mem_rd;
        end
    end

    rv_decoder u_decoder (
        .instr      (if_id_instr),
        .alu_op     (dec_alu_op),
        .imm        (dec_imm),
        .use_imm    (dec_use_imm),
        .reg_we     (dec_reg_we),
        .mem_we     (dec_mem_we),
        .mem_to_reg (dec_mem_to_reg),
        .branch     (dec_branch),
        .branch_ne  (dec_branch_ne)
    );

    rv_reg_file u_reg_file (
        .clk (clk),
        .ra1 (if_id_instr[19:15]),
        .ra2 (if_id_instr[24:20]),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .wa  (mem_wb_rd),
        .wd  (wb_data),
        .we  (mem_wb_reg_we && run)
    );

    assign alu_b = id_ex_use_imm ? id_ex_imm : id_ex_rd2;

    rv_alu u_alu (
        .a      (id_ex_rd1),
        .b      (alu_b),
        .op     (id_ex_alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // beq takes on equal, bne on not equal
    assign branch_taken  = id_ex_branch && (alu_equal != id_ex_branch_ne);
    assign branch_target = id_ex_pc + id_ex_imm;

    assign addr_dm = ex_mem_result;
    assign wd_dm   = ex_mem_rd2;
    assign we_dm   = ex_mem_mem_we && run;

    // load data comes straight from the memory output register
    assign wb_data = mem_wb_mem_to_reg ? rd_dm : mem_wb_result;

endmodule : rv_pipe_core

//--- source/rv_pipe_top.sv
`timescale 1ns/1ps

module rv_pipe_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  rv_bus_pkg::wb_adr_t  adr,
    input  rv_bus_pkg::word_t    dat_w,
    output rv_bus_pkg::word_t    dat_r,
    output logic                 ack
);

    logic               run;
    logic               imem_we;
    logic               dmem_host_stb;
    logic               dmem_host_we;
    logic [9:0]         host_index;
    rv_bus_pkg::word_t  host_wdata;
    rv_bus_pkg::word_t  dmem_host_rdata;
    rv_bus_pkg::addr_t  instr_addr;
    rv_bus_pkg::word_t  instr;
    rv_bus_pkg::addr_t  addr_dm;
    logic               we_dm;
    rv_bus_pkg::word_t  wd_dm;
    rv_bus_pkg::word_t  rd_dm;

    rv_host_regs u_host_regs (
        .clk             (clk),
        .rst             (rst),
        .cyc             (cyc),
        .stb             (stb),
        .we              (we),
        .adr             (adr),
        .dat_w           (dat_w),
        .instr_addr      (instr_addr),
        .dmem_host_rdata (dmem_host_rdata),
        .dat_r           (dat_r),
        .ack             (ack),
        .run             (run),
        .imem_we         (imem_we),
        .dmem_host_stb   (dmem_host_stb),
        .dmem_host_we    (dmem_host_we),
        .host_index      (host_index),
        .host_wdata      (host_wdata)
    );

    rv_memories #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memories (
        .clk             (clk),
        .imem_we         (imem_we),
        .dmem_host_stb   (dmem_host_stb),
        .dmem_host_we    (dmem_host_we),
        .host_index      (host_index),
        .host_wdata      (host_wdata),
        .instr_addr      (instr_addr),
        .addr_dm         (addr_dm),
        .we_dm           (we_dm),
        .wd_dm           (wd_dm),
        .instr           (instr),
        .rd_dm           (rd_dm),
        .dmem_host_rdata (dmem_host_rdata)
    );

    rv_pipe_core u_core (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .instr      (instr),
        .rd_dm      (rd_dm),
        .instr_addr (instr_addr),
        .addr_dm    (addr_dm),
        .we_dm      (we_dm),
        .wd_dm      (wd_dm)
    );

endmodule : rv_pipe_top

//--- source/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file (
    input  logic                   clk,
    input  rv_isa_pkg::reg_addr_t  ra1,
    input  rv_isa_pkg::reg_addr_t  ra2,
    output rv_bus_pkg::word_t      rd1,
    output rv_bus_pkg::word_t      rd2,
    input  rv_isa_pkg::reg_addr_t  wa,
    input  rv_bus_pkg::word_t      wd,
    input  logic                   we
);

    rv_bus_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-back value is visible to decode in the same cycle
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule : rv_reg_file

//--- verification/rv_pipe_assertions.sv
`timescale 1ns/1ps

module rv_pipe_assertions (
    input logic               clk,
    input logic               rst,
    input logic               cyc,
    input logic               stb,
    input logic               ack,
    input logic               run,
    input logic               we_dm,
    input rv_bus_pkg::addr_t  instr_addr
);

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else $error("ack longer than one cycle");

    // no store held in the memory stage across a stop
    no_write_when_stopped: assert property (@(posedge clk) disable iff (rst)
        !run |=> !we_dm)
        else $error("data memory write while run is low");

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        instr_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule : rv_pipe_assertions

bind rv_pipe_top rv_pipe_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .cyc        (cyc),
    .stb        (stb),
    .ack        (ack),
    .run        (run),
    .we_dm      (we_dm),
    .instr_addr (instr_addr)
);

//--- verification/rv_pipe_tb.sv
`timescale 1ns/1ps

module rv_pipe_tb;

    localparam int NUM_ROWS = 16;
    localparam int PROG_WORDS = 15;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 400;

    // kind 0 register op, 1 immediate op, 2 lui, 3 branch taken, 4 branch not taken
    localparam int ROW_KIND [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 2, 3, 4, 3, 4};
    localparam logic [2:0] ROW_F3 [NUM_ROWS] = '{
        3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd2,
        3'd0, 3'd7, 3'd6, 3'd0, 3'd0, 3'd0, 3'd1, 3'd1};
    localparam logic [6:0] ROW_F7 [NUM_ROWS] = '{
        7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
        7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
    localparam logic [31:0] ROW_IMM [NUM_ROWS] = '{
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
        32'hffb, 32'h0f0, 32'h8a5, 32'habcde, 32'h8, 32'h8, 32'h8, 32'h8};

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    rv_bus_pkg::wb_adr_t  adr;
    rv_bus_pkg::word_t    dat_w;
    rv_bus_pkg::word_t    dat_r;
    logic                 ack;

    logic [31:0]  rand_state;
    int           checks;
    int           value_errors;
    int           bus_errors;
    int           base_word;

    rv_pipe_top #(
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) DUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encode_instr(input rv_isa_pkg::opcode_e opcode,
            input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        case (opcode)
            rv_isa_pkg::OP:     return {f7, rs2, rs1, f3, rd, opcode};
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::LOAD:   return {imm[11:0], rs1, f3, rd, opcode};
            rv_isa_pkg::STORE:  return {imm[11:5], rs2, rs1, f3, imm[4:0], opcode};
            rv_isa_pkg::BRANCH: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                opcode};
            rv_isa_pkg::LUI:    return {imm[19:0], rd, opcode};
            default:            return rv_isa_pkg::NOP_INSTR;
        endcase
    endfunction

    // reference results straight from the RV32I definitions
    function automatic logic [31:0] model_result(input int kind, input logic [2:0] f3,
            input logic [6:0] f7, input logic [31:0] imm, input logic [31:0] a,
            input logic [31:0] b);
        logic [31:0] simm;
        simm = {{20{imm[11]}}, imm[11:0]};
        if (kind == 2) begin
            return {imm[19:0], 12'b0};
        end
        if (kind == 1) begin
            b = simm;
        end
        case (f3)
            3'd0:    return (kind == 0 && f7[5]) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic wb_cycle(input logic write, input rv_bus_pkg::wb_adr_t a,
            input logic [31:0] d, output logic [31:0] rdata);
        logic got;
        got = 1'b0;
        rdata = '0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= d;
        for (int i = 0; i < 8 && !got; i++) begin
            @(negedge clk);
            got = ack;
        end
        rdata = dat_r;
        if (!got) begin
            $display("no ack within 8 cycles for bus access to address %h", a);
            bus_errors++;
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input rv_bus_pkg::wb_adr_t a, input logic [31:0] d);
        logic [31:0] unused;
        wb_cycle(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input rv_bus_pkg::wb_adr_t a, output logic [31:0] d);
        wb_cycle(1'b0, a, 32'h0, d);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    function automatic rv_bus_pkg::wb_adr_t dmem_adr(input int word);
        return rv_bus_pkg::DMEM_BASE + rv_bus_pkg::wb_adr_t'(word * 4);
    endfunction

    task automatic run_row(input int r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp;
        logic [31:0] got;
        logic [31:0] status;
        logic [31:0] prog [PROG_WORDS];
        logic        taken;
        int          kind;
        kind = ROW_KIND[r];
        rand_state = xorshift32(rand_state);
        a = rand_state;
        rand_state = xorshift32(rand_state);
        b = rand_state;
        taken = (kind == 3);
        if (kind >= 3) begin
            // beq wants equal operands to take, bne wants them different
            b = ((ROW_F3[r] == rv_isa_pkg::F3_BEQ) == taken) ? a : a ^ 32'h1;
        end
        exp = (kind >= 3) ? (taken ? ~a : a) : model_result(kind, ROW_F3[r], ROW_F7[r],
            ROW_IMM[r], a, b);
        wb_write(dmem_adr(0), a);
        wb_write(dmem_adr(1), b);
        wb_write(dmem_adr(2), ~exp);
        wb_write(dmem_adr(3), ~a);
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = rv_isa_pkg::NOP_INSTR;
        end
        prog[0] = encode_instr(rv_isa_pkg::LOAD, rv_isa_pkg::F3_WORD, 7'h0, 5'd1, 5'd0, 5'd0,
            32'd0);
        prog[1] = encode_instr(rv_isa_pkg::LOAD, rv_isa_pkg::F3_WORD, 7'h0, 5'd2, 5'd0, 5'd0,
            32'd4);
        case (kind)
            0: prog[5] = encode_instr(rv_isa_pkg::OP, ROW_F3[r], ROW_F7[r], 5'd3, 5'd1, 5'd2,
                32'd0);
            1: prog[5] = encode_instr(rv_isa_pkg::OP_IMM, ROW_F3[r], 7'h0, 5'd3, 5'd1, 5'd0,
                ROW_IMM[r]);
            2: prog[5] = encode_instr(rv_isa_pkg::LUI, 3'd0, 7'h0, 5'd3, 5'd0, 5'd0, ROW_IMM[r]);
            default: begin
                // target skips the marker store right behind the branch
                prog[5] = encode_instr(rv_isa_pkg::BRANCH, ROW_F3[r], 7'h0, 5'd0, 5'd1, 5'd2,
                    ROW_IMM[r]);
                prog[6] = encode_instr(rv_isa_pkg::STORE, rv_isa_pkg::F3_WORD, 7'h0, 5'd0, 5'd0,
                    5'd1, 32'd12);
            end
        endcase
        prog[9] = encode_instr(rv_isa_pkg::STORE, rv_isa_pkg::F3_WORD, 7'h0, 5'd0, 5'd0, 5'd3,
            32'd8);
        for (int i = 0; i < PROG_WORDS; i++) begin
            wb_write(rv_bus_pkg::IMEM_BASE + rv_bus_pkg::wb_adr_t'(((base_word + i) % 256) * 4),
                prog[i]);
        end
        wb_write(rv_bus_pkg::REG_STOP, 32'((base_word + PROG_WORDS - 1) * 4));
        wb_write(rv_bus_pkg::REG_CTRL, 32'h1);
        status = '0;
        while (!status[0]) begin
            wb_read(rv_bus_pkg::REG_STATUS, status);
        end
        check_value("status after run", status, 32'h1);
        // pc stops one word past the stop address
        base_word = base_word + PROG_WORDS;
        wb_read(dmem_adr(kind >= 3 ? 3 : 2), got);
        check_value($sformatf("row %0d result", r), got, exp);
        // idle core must leave results alone
        wb_write(dmem_adr(10), a ^ b);
        repeat (20) @(posedge clk);
        wb_read(dmem_adr(kind >= 3 ? 3 : 2), got);
        check_value($sformatf("row %0d result after idle", r), got, exp);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, simulation did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        rand_state = 32'h11a7;
        checks = 0;
        value_errors = 0;
        bus_errors = 0;
        base_word = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wb_read(rv_bus_pkg::REG_STATUS, rd);
        check_value("status after reset", rd, 32'h0);
        wb_write(dmem_adr(5), 32'h5a5a_c3c3);
        wb_read(dmem_adr(5), rd);
        check_value("host data readback", rd, 32'h5a5a_c3c3);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("checks: %0d, value errors: %0d, bus errors: %0d",
            checks, value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : rv_pipe_tb
